//--- rtl/la_core_pkg.sv
package la_core_pkg;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    // Three views of one instruction word.
    typedef union packed {
        struct packed {
            logic [16:0] op;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } regs;
        struct packed {
            logic [9:0]  op;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } imm12;
        struct packed {
            logic [5:0]  op6;
            logic [15:0] offs16;   // Also high part of si20 and low part of offs26.
            logic [4:0]  rj;
            logic [4:0]  rd;
        } offs;
    } inst_word_u;

    // Register and shift formats, bits 31 to 15.
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // 12-bit immediate format, bits 31 to 22.
    localparam logic [9:0]  op_addi_w = 10'h00a;
    localparam logic [9:0]  op_ld_w   = 10'h0a2;
    localparam logic [9:0]  op_st_w   = 10'h0a6;

    // Major opcode, bits 31 to 26. lu12i.w also needs bit 25 clear.
    localparam logic [5:0]  op_lu12i_w = 6'h05;
    localparam logic [5:0]  op_jirl    = 6'h13;
    localparam logic [5:0]  op_b       = 6'h14;
    localparam logic [5:0]  op_bl      = 6'h15;
    localparam logic [5:0]  op_beq     = 6'h16;
    localparam logic [5:0]  op_bne     = 6'h17;

endpackage

//--- rtl/inst_decoder.sv
module inst_decoder
    import la_core_pkg::*;
(
    input  inst_word_u  inst,
    output alu_op_t     alu_op,
    output logic [4:0]  rj,
    output logic [4:0]  rk,
    output logic [4:0]  rd,
    output logic [4:0]  rf_raddr2,
    output logic [31:0] imm,
    output logic [31:0] br_offs,
    output logic        is_branch_cond,
    output logic        is_bne,
    output logic        is_jump_pc,
    output logic        is_jirl,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        is_load,
    output logic        is_store,
    output logic        gr_we,
    output logic [4:0]  dest
);
    logic        is_3r;
    logic        is_shift;
    logic        inst_addi_w;
    logic        inst_ld_w;
    logic        inst_st_w;
    logic        inst_lu12i_w;
    logic        inst_b;
    logic        inst_bl;
    logic        inst_beq;
    logic        inst_bne;
    logic [25:0] offs26;

    assign is_3r = inst.regs.op inside {op_add_w, op_sub_w, op_slt, op_sltu,
                                        op_nor, op_and, op_or, op_xor};
    assign is_shift = inst.regs.op inside {op_slli_w, op_srli_w, op_srai_w};

    assign inst_addi_w  = inst.imm12.op == op_addi_w;
    assign inst_ld_w    = inst.imm12.op == op_ld_w;
    assign inst_st_w    = inst.imm12.op == op_st_w;
    assign inst_lu12i_w = (inst.offs.op6 == op_lu12i_w) && !inst.offs.offs16[15];
    assign is_jirl      = inst.offs.op6 == op_jirl;
    assign inst_b       = inst.offs.op6 == op_b;
    assign inst_bl      = inst.offs.op6 == op_bl;
    assign inst_beq     = inst.offs.op6 == op_beq;
    assign inst_bne     = inst.offs.op6 == op_bne;

    always_comb begin
        case (inst.regs.op)
            op_sub_w:  alu_op = alu_sub;
            op_slt:    alu_op = alu_slt;
            op_sltu:   alu_op = alu_sltu;
            op_and:    alu_op = alu_and;
            op_nor:    alu_op = alu_nor;
            op_or:     alu_op = alu_or;
            op_xor:    alu_op = alu_xor;
            op_slli_w: alu_op = alu_sll;
            op_srli_w: alu_op = alu_srl;
            op_srai_w: alu_op = alu_sra;
            default:   alu_op = alu_add; // Sums, addresses and link values.
        endcase
        if (inst_lu12i_w)
            alu_op = alu_lui;
    end

    assign rj = inst.regs.rj;
    assign rk = inst.regs.rk;
    assign rd = inst.regs.rd;

    // Stores and compares read rd as the second source.
    assign rf_raddr2 = (inst_st_w || inst_beq || inst_bne) ? rd : rk;

    assign imm = (is_jirl || inst_bl) ? 32'd4 :
                 inst_lu12i_w ? {inst.offs.offs16[14:0], inst.offs.rj, 12'b0} :
                 is_shift ? {27'b0, inst.regs.rk} :
                 {{20{inst.imm12.si12[11]}}, inst.imm12.si12};

    assign offs26  = {inst.offs.rj, inst.offs.rd, inst.offs.offs16};
    assign br_offs = is_jump_pc ? {{4{offs26[25]}}, offs26, 2'b0} :
                                  {{14{inst.offs.offs16[15]}}, inst.offs.offs16, 2'b0};

    assign is_branch_cond = inst_beq || inst_bne;
    assign is_bne         = inst_bne;
    assign is_jump_pc     = inst_b || inst_bl;
    assign src1_is_pc     = is_jirl || inst_bl;
    assign src2_is_imm    = is_shift || inst_addi_w || inst_ld_w || inst_st_w
                            || inst_lu12i_w || is_jirl || inst_bl;
    assign is_load        = inst_ld_w;
    assign is_store       = inst_st_w;
    assign gr_we = is_3r || is_shift || inst_addi_w || inst_lu12i_w || inst_ld_w
                   || is_jirl || inst_bl;
    assign dest  = inst_bl ? 5'd1 : rd; // bl links to r1.

endmodule

//--- rtl/alu.sv
module alu
    import la_core_pkg::*;
(
    input  alu_op_t     alu_op,
    input  logic [31:0] alu_src1,
    input  logic [31:0] alu_src2,
    output logic [31:0] alu_result
);
    logic [4:0]  shamt;
    logic [31:0] diff;

    assign shamt = alu_src2[4:0];
    assign diff  = alu_src1 - alu_src2;

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = alu_src1 + alu_src2;
            alu_sub:  alu_result = diff;
            alu_slt:  alu_result = {31'd0, $signed(alu_src1) < $signed(alu_src2)};
            alu_sltu: alu_result = {31'd0, alu_src1 < alu_src2};
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_sll:  alu_result = alu_src1 << shamt;
            alu_srl:  alu_result = alu_src1 >> shamt;
            alu_sra:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            alu_lui:  alu_result = alu_src2;  // Immediate is already shifted.
            default:  alu_result = 32'd0;
        endcase
    end

endmodule

//--- rtl/regfile.sv
module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we)
            regs[waddr] <= wdata;
    end

    // r0 reads as zero whatever was written to it.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- rtl/cpu_top.sv
module cpu_top
    import la_core_pkg::*;
#(
    parameter logic [31:0] reset_addr = reset_pc
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    localparam logic [2:0] st_fetch     = 3'd0;
    localparam logic [2:0] st_decode    = 3'd1;
    localparam logic [2:0] st_execute   = 3'd2;
    localparam logic [2:0] st_memory    = 3'd3;
    localparam logic [2:0] st_writeback = 3'd4;

    logic [2:0]  state;
    logic [2:0]  state_next;
    logic [31:0] pc;
    logic [31:0] npc_reg;
    logic [31:0] inst_reg;
    logic [31:0] src1_reg;
    logic [31:0] src2_reg;
    logic [31:0] store_data;
    logic [31:0] result_reg;
    logic [31:0] load_data;

    inst_word_u  inst_cur;
    alu_op_t     alu_op;
    logic [4:0]  rj;
    logic [4:0]  rf_raddr2;
    logic [4:0]  dest;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic        is_branch_cond;
    logic        is_bne;
    logic        is_jump_pc;
    logic        is_jirl;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        is_load;
    logic        is_store;
    logic        gr_we;

    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] alu_result;
    logic        rf_we;
    logic [31:0] rf_wdata;

    logic        branch_only;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] seq_pc;
    logic [31:0] npc_d;

    // Fresh SRAM word while decoding, the latched copy after that.
    assign inst_cur = (state == st_decode) ? inst_sram_rdata : inst_reg;

    inst_decoder u_decoder (
        .inst           (inst_cur),
        .alu_op         (alu_op),
        .rj             (rj),
        .rk             (),
        .rd             (),
        .rf_raddr2      (rf_raddr2),
        .imm            (imm),
        .br_offs        (br_offs),
        .is_branch_cond (is_branch_cond),
        .is_bne         (is_bne),
        .is_jump_pc     (is_jump_pc),
        .is_jirl        (is_jirl),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .is_load        (is_load),
        .is_store       (is_store),
        .gr_we          (gr_we),
        .dest           (dest)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (src1_reg),
        .alu_src2   (src2_reg),
        .alu_result (alu_result)
    );

    // b has no link, so it ends with beq and bne after decode.
    assign branch_only = is_branch_cond || (is_jump_pc && !gr_we);

    assign seq_pc    = pc + 32'd4;
    assign br_taken  = (is_branch_cond && ((rj_value == rkd_value) != is_bne))
                       || is_jump_pc || is_jirl;
    assign br_target = (is_jirl ? rj_value : pc) + br_offs;
    assign npc_d     = br_taken ? br_target : seq_pc;

    always_comb begin
        case (state)
            st_fetch:   state_next = st_decode;
            st_decode:  state_next = branch_only ? st_fetch : st_execute;
            st_execute: state_next = (is_load || is_store) ? st_memory : st_writeback;
            st_memory:  state_next = is_load ? st_writeback : st_fetch;
            default:    state_next = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= reset_addr;
        end else begin
            state <= state_next;
            if (state == st_decode && branch_only)
                pc <= npc_d;
            else if (state == st_writeback || (state == st_memory && !is_load))
                pc <= npc_reg; // Instruction retires.
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_decode: begin
                inst_reg   <= inst_sram_rdata;
                npc_reg    <= npc_d;
                src1_reg   <= src1_is_pc ? pc : rj_value;
                src2_reg   <= src2_is_imm ? imm : rkd_value;
                store_data <= rkd_value;
            end
            st_execute: result_reg <= alu_result;
            st_memory:  load_data  <= data_sram_rdata;
            default: ;
        endcase
    end

    assign inst_sram_addr = pc;

    // Address is valid in EXECUTE; read data follows in MEMORY.
    assign data_sram_we    = (state == st_execute) && is_store;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data;

    assign rf_we    = (state == st_writeback) && gr_we;
    assign rf_wdata = is_load ? load_data : result_reg;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- testbench/cpu_checker.sv
module cpu_checker (
    input logic        clk,
    input logic        reset,
    input logic        data_sram_we,
    input logic        debug_wb_rf_we,
    input logic [31:0] pc
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Each store and each register write lasts one cycle.
    store_single: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
        else begin
            $error("data_sram_we high for two cycles");
            fail_count++;
        end

    write_single: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |=> !debug_wb_rf_we)
        else begin
            $error("debug_wb_rf_we high for two cycles");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!data_sram_we && !debug_wb_rf_we))
        else begin
            $error("write enable high right after reset");
            fail_count++;
        end

    // Sequential step or an aligned branch target.
    pc_step: assert property (@(posedge clk) disable iff (reset)
        (pc != $past(pc)) |-> (pc == $past(pc) + 32'd4 || pc[1:0] == 2'b00))
        else begin
            $error("pc moved to a misaligned address");
            fail_count++;
        end

endmodule

bind cpu_top cpu_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we),
    .pc             (pc)
);

//--- testbench/tb_top.sv
module tb_top
    import la_core_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [logic [31:0]];
    logic [31:0] mdmem [logic [31:0]];
    logic [31:0] mregs [32];
    logic [31:0] rng = 32'h26f6_e509;
    int          n_inst;
    int          n_exec;
    int          limit;
    int          cycles;
    int          settle;
    bit          reset_checked;
    logic [31:0] last_addr;
    logic [31:0] final_pc;
    logic [31:0] wr_pc_q[$];
    logic [4:0]  wr_num_q[$];
    logic [31:0] wr_data_q[$];
    int          wr_tag_q[$];
    logic [31:0] st_addr_q[$];
    logic [31:0] st_data_q[$];
    logic [31:0] pc_q[$];
    int          chk_cnt [5];
    int          err_cnt [5];
    string       test_name [5] = '{"reset", "register writes", "store and load",
                                   "branches and links", "r0 writes"};

    cpu_top #(.reset_addr(reset_pc)) dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] enc_reg(input logic [16:0] op, input logic [4:0] rk,
                                            input logic [4:0] rj, input logic [4:0] rd);
        inst_word_u w;
        w.regs.op = op;
        w.regs.rk = rk;
        w.regs.rj = rj;
        w.regs.rd = rd;
        return w;
    endfunction

    function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [11:0] si12,
                                            input logic [4:0] rj, input logic [4:0] rd);
        inst_word_u w;
        w.imm12.op   = op;
        w.imm12.si12 = si12;
        w.imm12.rj   = rj;
        w.imm12.rd   = rd;
        return w;
    endfunction

    function automatic logic [31:0] enc_offs(input logic [5:0] op6, input logic [15:0] offs16,
                                             input logic [4:0] rj, input logic [4:0] rd);
        inst_word_u w;
        w.offs.op6    = op6;
        w.offs.offs16 = offs16;
        w.offs.rj     = rj;
        w.offs.rd     = rd;
        return w;
    endfunction

    function automatic logic [31:0] enc_b26(input logic [5:0] op6, input logic [25:0] offs);
        return enc_offs(op6, offs[15:0], offs[25:21], offs[20:16]);
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [19:0] si20, input logic [4:0] rd);
        return {7'b0001010, si20, rd};
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (dmem.exists(addr[31:2]))
            return dmem[addr[31:2]];
        return addr ^ 32'hc3c3_c3c3; // Unwritten words.
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n_inst] = word;
        n_inst++;
    endtask

    task automatic check_val(input int t, input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        chk_cnt[t]++;
        assert (exp === got) else begin
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
            err_cnt[t]++;
        end
    endtask

    task automatic build_program();
        logic [31:0] v;
        logic [16:0] ops [11] = '{op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and,
                                  op_or, op_xor, op_slli_w, op_srli_w, op_srai_w};
        int j;
        for (int r = 1; r < 16; r++) begin
            v = next_rand();
            emit(enc_lu12i(v[19:0], 5'(r)));
            emit(enc_i12(op_addi_w, v[31:20], 5'(r), 5'(r)));
        end
        for (int i = 0; i < 60; i++) begin
            v = next_rand();
            if (v[3:0] >= 4'd11)
                emit(enc_i12(op_addi_w, v[31:20], {1'b0, v[23:20]}, {1'b0, v[19:16]}));
            else if (v[3:0] >= 4'd8)
                emit(enc_reg(ops[v[3:0]], v[12:8], {1'b0, v[23:20]}, {1'b0, v[19:16]}));
            else
                emit(enc_reg(ops[v[3:0]], {1'b0, v[11:8]}, {1'b0, v[23:20]},
                             {1'b0, v[19:16]})); // Sources among r0 to r15.
        end
        emit(enc_reg(op_add_w, 5'd2, 5'd1, 5'd0));   // Write to r0.
        emit(enc_reg(op_or, 5'd0, 5'd0, 5'd17));     // Reads r0 back.
        emit(enc_lu12i(20'h00010, 5'd16));
        emit(enc_i12(op_st_w, 12'h008, 5'd16, 5'd3));
        emit(enc_i12(op_st_w, 12'hffc, 5'd16, 5'd4));
        emit(enc_i12(op_ld_w, 12'h008, 5'd16, 5'd18));
        emit(enc_i12(op_ld_w, 12'hffc, 5'd16, 5'd19));
        emit(enc_offs(op_beq, 16'd2, 5'd16, 5'd16));
        emit(enc_i12(op_addi_w, 12'h7ff, 5'd0, 5'd20)); // Skipped.
        emit(enc_offs(op_beq, 16'd2, 5'd16, 5'd0));
        emit(enc_i12(op_addi_w, 12'h001, 5'd0, 5'd20));
        emit(enc_offs(op_bne, 16'd2, 5'd16, 5'd16));
        emit(enc_i12(op_addi_w, 12'h002, 5'd0, 5'd21));
        emit(enc_offs(op_bne, 16'd2, 5'd16, 5'd0));
        emit(enc_i12(op_addi_w, 12'h003, 5'd0, 5'd22));
        emit(enc_b26(op_bl, 26'd2));
        emit(enc_i12(op_addi_w, 12'h004, 5'd0, 5'd23)); // Skipped.
        emit(enc_lu12i(reset_pc[31:12], 5'd24));
        j = n_inst;
        emit(enc_offs(op_jirl, 16'(j + 2), 5'd24, 5'd25));
        emit(enc_i12(op_addi_w, 12'h005, 5'd0, 5'd26)); // Skipped.
        final_pc = reset_pc + 32'(n_inst * 4);
        emit(enc_b26(op_b, 26'd0));
    endtask

    // Instruction-level model, run ahead over the whole program.
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] bv;
        logic [31:0] dv;
        logic [31:0] val;
        logic [31:0] si12;
        logic [31:0] o16;
        logic [31:0] o26;
        logic [4:0]  dst;
        bit          wr;
        int          tag;
        pc = reset_pc;
        for (int k = 0; k < 1000; k++) begin
            w    = imem[(pc - reset_pc) >> 2];
            a    = mregs[w[9:5]];
            bv   = mregs[w[14:10]];
            dv   = mregs[w[4:0]];
            si12 = {{20{w[21]}}, w[21:10]};
            o16  = {{14{w[25]}}, w[25:10], 2'b00};
            o26  = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            npc  = pc + 32'd4;
            dst  = w[4:0];
            wr   = 1'b1;
            tag  = (dst == 5'd0 || w[9:5] == 5'd0 && w[14:10] == 5'd0) ? 4 : 1;
            n_exec++;
            case (w[31:15])
                op_add_w:  val = a + bv;
                op_sub_w:  val = a - bv;
                op_slt:    val = {31'd0, $signed(a) < $signed(bv)};
                op_sltu:   val = {31'd0, a < bv};
                op_nor:    val = ~(a | bv);
                op_and:    val = a & bv;
                op_or:     val = a | bv;
                op_xor:    val = a ^ bv;
                op_slli_w: val = a << w[14:10];
                op_srli_w: val = a >> w[14:10];
                op_srai_w: val = $signed(a) >>> w[14:10];
                default: begin
                    wr  = 1'b1;
                    tag = 1;
                    if (w[31:22] == op_addi_w) begin
                        val = a + si12;
                        if (dst == 5'd0)
                            tag = 4;
                    end else if (w[31:22] == op_ld_w) begin
                        val = mdmem[(a + si12) >> 2];
                        tag = 2;
                    end else if (w[31:22] == op_st_w) begin
                        wr = 1'b0;
                        mdmem[(a + si12) >> 2] = dv;
                        st_addr_q.push_back(a + si12);
                        st_data_q.push_back(dv);
                    end else if (w[31:25] == 7'b0001010) begin
                        val = {w[24:5], 12'b0};
                    end else if (w[31:26] == op_jirl) begin
                        val = pc + 32'd4;
                        npc = a + o16;
                        tag = 3;
                    end else if (w[31:26] == op_bl) begin
                        val = pc + 32'd4;
                        dst = 5'd1;
                        npc = pc + o26;
                        tag = 3;
                    end else begin
                        wr = 1'b0;
                        if (w[31:26] == op_b)
                            npc = pc + o26;
                        else if ((w[31:26] == op_beq) == (a == dv))
                            npc = pc + o16;
                    end
                end
            endcase
            if (wr) begin
                wr_pc_q.push_back(pc);
                wr_num_q.push_back(dst);
                wr_data_q.push_back(val);
                wr_tag_q.push_back(tag);
                if (dst != 5'd0)
                    mregs[dst] = val;
            end
            if (npc == pc)
                break;
            pc_q.push_back(npc);
            pc = npc;
        end
    endtask

    task automatic report();
        int errs = 0;
        int chks = 0;
        for (int t = 1; t < 5; t++)
            $display("test %s: %0d checks, %0d errors", test_name[t], chk_cnt[t], err_cnt[t]);
        for (int t = 0; t < 5; t++) begin
            errs += err_cnt[t];
            chks += chk_cnt[t];
        end
        errs += dut.u_checker.fail_count;
        $display("total: %0d checks, %0d errors", chks, errs);
        if (errs == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        for (int i = 0; i < 256; i++)
            imem[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h0001_0003);
        for (int i = 0; i < 32; i++)
            mregs[i] = 32'd0;
        build_program();
        run_model();
        limit     = 16 + 5 * n_exec + 200;
        last_addr = reset_pc;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

    // Synchronous SRAMs.
    always @(posedge clk) begin
        inst_sram_rdata <= imem[8'((inst_sram_addr - reset_pc) >> 2)];
        data_sram_rdata <= mem_read(data_sram_addr);
        if (data_sram_we)
            dmem[data_sram_addr[31:2]] = data_sram_wdata;
        cycles++;
        if (cycles > limit) begin
            $display("timeout: core did not reach the final branch in %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                check_val(0, "inst_sram_addr", reset_pc, inst_sram_addr);
                check_val(0, "data_sram_we", 32'd0, 32'(data_sram_we));
                check_val(0, "debug_wb_rf_we", 32'd0, 32'(debug_wb_rf_we));
                $display("test %s: %0d checks, %0d errors", test_name[0], chk_cnt[0],
                         err_cnt[0]);
            end
            if (debug_wb_rf_we) begin
                if (wr_pc_q.size() == 0) begin
                    $display("register write at %0t ns that the model did not expect", $time);
                    err_cnt[1]++;
                end else begin
                    check_val(wr_tag_q[0], "debug_wb_pc", wr_pc_q.pop_front(), debug_wb_pc);
                    check_val(wr_tag_q[0], "debug_wb_rf_wnum", 32'(wr_num_q.pop_front()),
                              32'(debug_wb_rf_wnum));
                    check_val(wr_tag_q.pop_front(), "debug_wb_rf_wdata",
                              wr_data_q.pop_front(), debug_wb_rf_wdata);
                end
            end
            if (data_sram_we) begin
                if (st_addr_q.size() == 0) begin
                    $display("memory write at %0t ns that the model did not expect", $time);
                    err_cnt[2]++;
                end else begin
                    check_val(2, "data_sram_addr", st_addr_q.pop_front(), data_sram_addr);
                    check_val(2, "data_sram_wdata", st_data_q.pop_front(), data_sram_wdata);
                end
            end
            if (inst_sram_addr != last_addr) begin
                if (pc_q.size() == 0) begin
                    $display("fetch address changed after the program ended");
                    err_cnt[3]++;
                end else begin
                    check_val(3, "inst_sram_addr", pc_q.pop_front(), inst_sram_addr);
                end
                last_addr = inst_sram_addr;
            end
            if (pc_q.size() == 0 && wr_pc_q.size() == 0 && st_addr_q.size() == 0
                && inst_sram_addr == final_pc) begin
                settle++;
                if (settle == 8)
                    report();
            end
        end
    end

endmodule

//--- filelist.f
rtl/la_core_pkg.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/regfile.sv
rtl/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_top -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation finished: PASS" sim.log
